//--- hw/iopage_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O page shared definitions
// register offsets, timing constants, interrupt levels and bus structs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package iopage_pkg;

   // register offsets within the 8 KB I/O page
   localparam logic [12:0] LKS_ADDR  = 13'o17546;
   localparam logic [12:0] RCSR_ADDR = 13'o17560;
   localparam logic [12:0] RBUF_ADDR = 13'o17562;
   localparam logic [12:0] XCSR_ADDR = 13'o17564;
   localparam logic [12:0] XBUF_ADDR = 13'o17566;
   localparam logic [12:0] SR_ADDR   = 13'o17570;
   localparam logic [12:0] PSW_ADDR  = 13'o17776;

   localparam logic [15:0] NO_DECODE_DATA = 16'h002f;

   // short line-clock period keeps simulation fast
   localparam logic [23:0] LINE_CLK_DIV = 24'd200;
   localparam logic [7:0]  BIT_PERIOD   = 8'd16;

   localparam logic [2:0] CLK_IPL = 3'd6;
   localparam logic [2:0] TT_IPL  = 3'd4;

   localparam logic [7:0] CLK_VEC   = 8'o100;
   localparam logic [7:0] TT_RX_VEC = 8'o60;
   localparam logic [7:0] TT_TX_VEC = 8'o64;

   typedef struct packed {
      logic [12:0] addr;
      logic [15:0] wdata;
      logic        rd;
      logic        wr;
      logic        byte_op;
   } io_req_t;

   typedef struct packed {
      logic [15:0] rdata;
      logic        decode;
   } io_resp_t;

   typedef struct packed {
      logic       req;
      logic [7:0] vec;
   } irq_t;

   typedef enum logic [1:0] {SER_IDLE, SER_START, SER_DATA, SER_STOP} ser_state_e;

endpackage

//--- hw/tt_serial.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 serial transmitter and receiver at a fixed bit period
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tt_serial (
   input  logic       clk,
   input  logic       rst,
   input  logic       tx_start,
   input  logic [7:0] tx_byte,
   input  logic       rx,
   output logic       tx_busy,
   output logic       tx,
   output logic       rx_valid,
   output logic [7:0] rx_byte
);
   import iopage_pkg::*;

   ser_state_e tx_state, rx_state;
   logic [7:0] tx_cnt, rx_cnt;
   logic [2:0] tx_bit, rx_bit;
   logic [7:0] tx_shift, rx_shift;
   logic       tx_last, rx_last;
   logic       rx_meta, rx_s;

   assign tx_last = (tx_cnt == BIT_PERIOD - 8'd1);
   assign tx_busy = (tx_state != SER_IDLE);
   assign tx      = (tx_state == SER_START) ? 1'b0 :
                    (tx_state == SER_DATA)  ? tx_shift[0] : 1'b1;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         tx_state <= SER_IDLE;
         tx_cnt   <= 8'd0;
         tx_bit   <= 3'd0;
      end
      else if (tx_state == SER_IDLE)
      begin
         tx_cnt <= 8'd0;
         if (tx_start)
            tx_state <= SER_START;
      end
      else if (!tx_last)
         tx_cnt <= tx_cnt + 8'd1;
      else
      begin
         tx_cnt <= 8'd0;
         case (tx_state)
            SER_START: tx_state <= SER_DATA;
            SER_DATA:
            begin
               tx_bit <= tx_bit + 3'd1;
               if (tx_bit == 3'd7)
                  tx_state <= SER_STOP;
            end
            default:   tx_state <= SER_IDLE;
         endcase
      end
   end

   // lsb goes out first
   always_ff @(posedge clk)
   begin
      if (tx_start && tx_state == SER_IDLE)
         tx_shift <= tx_byte;
      else if (tx_state == SER_DATA && tx_last)
         tx_shift <= {1'b0, tx_shift[7:1]};
   end

   // line idles high
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rx_meta <= 1'b1;
         rx_s    <= 1'b1;
      end
      else
      begin
         rx_meta <= rx;
         rx_s    <= rx_meta;
      end
   end

   // half a bit into the start bit, then whole bits to each midpoint
   assign rx_last = (rx_state == SER_START) ? (rx_cnt == (BIT_PERIOD >> 1) - 8'd1) :
                                              (rx_cnt == BIT_PERIOD - 8'd1);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rx_state <= SER_IDLE;
         rx_cnt   <= 8'd0;
         rx_bit   <= 3'd0;
         rx_valid <= 1'b0;
      end
      else
      begin
         rx_valid <= 1'b0;
         if (rx_state == SER_IDLE)
         begin
            rx_cnt <= 8'd0;
            if (!rx_s)
               rx_state <= SER_START;
         end
         else if (!rx_last)
            rx_cnt <= rx_cnt + 8'd1;
         else
         begin
            rx_cnt <= 8'd0;
            case (rx_state)
               // a start bit gone high at its middle was a glitch
               SER_START: rx_state <= rx_s ? SER_IDLE : SER_DATA;
               SER_DATA:
               begin
                  rx_bit <= rx_bit + 3'd1;
                  if (rx_bit == 3'd7)
                     rx_state <= SER_STOP;
               end
               default:
               begin
                  rx_state <= SER_IDLE;
                  rx_valid <= rx_s;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rx_state == SER_DATA && rx_last)
         rx_shift <= {rx_s, rx_shift[7:1]};
   end

   assign rx_byte = rx_shift;

endmodule

//--- hw/tt_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// console terminal registers RCSR, RBUF, XCSR and XBUF
// done/ready flags and a shared interrupt with receive first
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tt_regs (
   input  logic                 clk,
   input  logic                 rst,
   input  iopage_pkg::io_req_t  req,
   input  logic                 ack,
   input  logic                 rs232_rx,
   output iopage_pkg::io_resp_t resp,
   output iopage_pkg::irq_t     irq,
   output logic                 rs232_tx
);
   import iopage_pkg::*;

   logic        rcsr_hit, rbuf_hit, xcsr_hit, xbuf_hit;
   logic        lo_wr;
   logic        tx_start;
   logic        tx_busy;
   logic        tx_busy_q;
   logic        tx_done;
   logic        rx_valid;
   logic [7:0]  rx_byte;
   logic [7:0]  rbuf;
   logic        rx_done, rx_ie, tx_ie;
   logic        rx_pend, tx_pend;
   logic [15:0] rdata;

   assign rcsr_hit = (req.addr[12:1] == RCSR_ADDR[12:1]);
   assign rbuf_hit = (req.addr[12:1] == RBUF_ADDR[12:1]);
   assign xcsr_hit = (req.addr[12:1] == XCSR_ADDR[12:1]);
   assign xbuf_hit = (req.addr[12:1] == XBUF_ADDR[12:1]);
   assign lo_wr    = req.wr & (~req.byte_op | ~req.addr[0]);

   // ready is simply the shifter being idle
   assign tx_start = lo_wr & xbuf_hit & ~tx_busy;
   assign tx_done  = tx_busy_q & ~tx_busy;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rx_done   <= 1'b0;
         rx_ie     <= 1'b0;
         tx_ie     <= 1'b0;
         tx_busy_q <= 1'b0;
         rx_pend   <= 1'b0;
         tx_pend   <= 1'b0;
      end
      else
      begin
         tx_busy_q <= tx_busy;
         if (rx_valid)
            rx_done <= 1'b1;
         else if (req.rd && rbuf_hit)
            rx_done <= 1'b0;
         if (lo_wr && rcsr_hit)
            rx_ie <= req.wdata[6];
         if (lo_wr && xcsr_hit)
            tx_ie <= req.wdata[6];
         // ack retires whichever source is presented
         if (rx_valid && rx_ie)
            rx_pend <= 1'b1;
         else if (ack && rx_pend)
            rx_pend <= 1'b0;
         if (tx_done && tx_ie)
            tx_pend <= 1'b1;
         else if (ack && !rx_pend)
            tx_pend <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rx_valid)
         rbuf <= rx_byte;
   end

   always_comb
   begin
      rdata = 16'h0000;
      if (rcsr_hit)
         rdata = {8'h00, rx_done, rx_ie, 6'b000000};
      else if (rbuf_hit)
         rdata = {8'h00, rbuf};
      else if (xcsr_hit)
         rdata = {8'h00, ~tx_busy, tx_ie, 6'b000000};
   end

   assign resp = '{rdata: rdata, decode: rcsr_hit | rbuf_hit | xcsr_hit | xbuf_hit};
   assign irq  = '{req: rx_pend | tx_pend, vec: rx_pend ? TT_RX_VEC : TT_TX_VEC};

   tt_serial tt_serial_inst (
      .clk      (clk),
      .rst      (rst),
      .tx_start (tx_start),
      .tx_byte  (req.wdata[7:0]),
      .rx       (rs232_rx),
      .tx_busy  (tx_busy),
      .tx       (rs232_tx),
      .rx_valid (rx_valid),
      .rx_byte  (rx_byte)
   );

endmodule

//--- hw/clk_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line-time clock with LKS status register and periodic interrupt
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module clk_regs (
   input  logic                 clk,
   input  logic                 rst,
   input  iopage_pkg::io_req_t  req,
   input  logic                 ack,
   output iopage_pkg::io_resp_t resp,
   output iopage_pkg::irq_t     irq
);
   import iopage_pkg::*;

   logic [23:0] div_cnt;
   logic        tick;
   logic        lks_hit;
   logic        lks_wr;
   logic        lks_mon;
   logic        lks_ie;
   logic        irq_pend;
   logic        ie_raise;

   assign tick    = (div_cnt == LINE_CLK_DIV - 24'd1);
   assign lks_hit = (req.addr[12:1] == LKS_ADDR[12:1]);
   // both control bits sit in the low byte
   assign lks_wr  = req.wr & lks_hit & (~req.byte_op | ~req.addr[0]);

   // enabling while the monitor bit stays set requests at once
   assign ie_raise = lks_wr & req.wdata[6] & req.wdata[7] & lks_mon & ~lks_ie;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         div_cnt  <= 24'd0;
         lks_mon  <= 1'b0;
         lks_ie   <= 1'b0;
         irq_pend <= 1'b0;
      end
      else
      begin
         div_cnt <= tick ? 24'd0 : div_cnt + 24'd1;
         if (tick)
            lks_mon <= 1'b1;
         else if (lks_wr && !req.wdata[7])
            lks_mon <= 1'b0;
         if (lks_wr)
            lks_ie <= req.wdata[6];
         if ((tick && lks_ie) || ie_raise)
            irq_pend <= 1'b1;
         else if (ack)
            irq_pend <= 1'b0;
      end
   end

   assign resp = '{rdata: lks_hit ? {8'h00, lks_mon, lks_ie, 6'b000000} : 16'h0000,
                   decode: lks_hit};
   assign irq  = '{req: irq_pend, vec: CLK_VEC};

endmodule

//--- hw/console_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// console block with switch and display registers and PSW access
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module console_regs (
   input  logic                 clk,
   input  logic                 rst,
   input  iopage_pkg::io_req_t  req,
   input  logic [15:0]          psw_in,
   input  logic [15:0]          switches,
   output iopage_pkg::io_resp_t resp,
   output logic                 psw_io_wr,
   output logic [15:0]          psw_out,
   output logic [15:0]          display
);
   import iopage_pkg::*;

   logic sr_hit;
   logic psw_hit;

   // byte data arrives in its own lane of wdata
   function automatic logic [15:0] merge_bytes(input logic [15:0] old_val,
                                               input io_req_t     r);
      if (!r.byte_op)
         return r.wdata;
      return r.addr[0] ? {r.wdata[15:8], old_val[7:0]} : {old_val[15:8], r.wdata[7:0]};
   endfunction

   assign sr_hit  = (req.addr[12:1] == SR_ADDR[12:1]);
   assign psw_hit = (req.addr[12:1] == PSW_ADDR[12:1]);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         display   <= 16'h0000;
         psw_io_wr <= 1'b0;
      end
      else
      begin
         psw_io_wr <= req.wr & psw_hit;
         if (req.wr && sr_hit)
            display <= merge_bytes(display, req);
      end
   end

   // cpu loads psw_out on the psw_io_wr pulse
   always_ff @(posedge clk)
   begin
      if (req.wr && psw_hit)
         psw_out <= merge_bytes(psw_in, req);
   end

   assign resp = '{rdata: sr_hit ? switches : psw_hit ? psw_in : 16'h0000,
                   decode: sr_hit | psw_hit};

endmodule

//--- hw/iopage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O page top level
// decodes device registers, steers read data and arbitrates interrupts
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module iopage (
   input  logic        clk,
   input  logic        rst,
   input  logic [21:0] address,
   input  logic [15:0] data_in,
   input  logic        iopage_rd,
   input  logic        iopage_wr,
   input  logic        iopage_byte_op,
   input  logic [7:0]  ack_ipl,
   input  logic [15:0] psw,
   input  logic [15:0] switches,
   input  logic        rs232_rx,
   output logic [15:0] data_out,
   output logic        no_decode,
   output logic        interrupt,
   output logic [7:0]  interrupt_ipl,
   output logic [7:0]  vector,
   output logic        psw_io_wr,
   output logic [15:0] psw_out,
   output logic [15:0] display,
   output logic        rs232_tx
);
   import iopage_pkg::*;

   io_req_t  req;
   io_resp_t clk_resp;
   io_resp_t tt_resp;
   io_resp_t con_resp;
   irq_t     clk_irq;
   irq_t     tt_irq;

   // upper address bits are already qualified by the cpu strobes
   assign req = '{addr: address[12:0], wdata: data_in, rd: iopage_rd,
                  wr: iopage_wr, byte_op: iopage_byte_op};

   assign data_out = clk_resp.decode ? clk_resp.rdata :
                     tt_resp.decode  ? tt_resp.rdata :
                     con_resp.decode ? con_resp.rdata :
                     NO_DECODE_DATA;

   assign no_decode = (iopage_rd | iopage_wr) &
                      ~(clk_resp.decode | tt_resp.decode | con_resp.decode);

   assign interrupt = clk_irq.req | tt_irq.req;

   always_comb
   begin
      interrupt_ipl          = 8'h00;
      interrupt_ipl[CLK_IPL] = clk_irq.req;
      interrupt_ipl[TT_IPL]  = tt_irq.req;
   end

   // highest level first
   assign vector = clk_irq.req ? clk_irq.vec :
                   tt_irq.req  ? tt_irq.vec :
                   8'h00;

   clk_regs clk_regs_inst (
      .clk  (clk),
      .rst  (rst),
      .req  (req),
      .ack  (ack_ipl[CLK_IPL]),
      .resp (clk_resp),
      .irq  (clk_irq)
   );

   tt_regs tt_regs_inst (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .ack      (ack_ipl[TT_IPL]),
      .rs232_rx (rs232_rx),
      .resp     (tt_resp),
      .irq      (tt_irq),
      .rs232_tx (rs232_tx)
   );

   console_regs console_regs_inst (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .psw_in    (psw),
      .switches  (switches),
      .resp      (con_resp),
      .psw_io_wr (psw_io_wr),
      .psw_out   (psw_out),
      .display   (display)
   );

endmodule

//--- tests/tb_iopage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O page testbench
// directed tests for decode, console, line clock, terminal and priority
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_iopage;
   timeunit 1ns;
   timeprecision 1ps;
   import iopage_pkg::*;

   logic        clk;
   logic        rst;
   logic [21:0] address;
   logic [15:0] data_in;
   logic        iopage_rd;
   logic        iopage_wr;
   logic        iopage_byte_op;
   logic [7:0]  ack_ipl;
   logic [15:0] psw;
   logic [15:0] switches;
   logic [15:0] data_out;
   logic        no_decode;
   logic        interrupt;
   logic [7:0]  interrupt_ipl;
   logic [7:0]  vector;
   logic        psw_io_wr;
   logic [15:0] psw_out;
   logic [15:0] display;
   wire         serial_loop;

   int errors;
   int tests_run;

   iopage iopage_inst (
      .clk            (clk),
      .rst            (rst),
      .address        (address),
      .data_in        (data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .ack_ipl        (ack_ipl),
      .psw            (psw),
      .switches       (switches),
      .rs232_rx       (serial_loop),
      .data_out       (data_out),
      .no_decode      (no_decode),
      .interrupt      (interrupt),
      .interrupt_ipl  (interrupt_ipl),
      .vector         (vector),
      .psw_io_wr      (psw_io_wr),
      .psw_out        (psw_out),
      .display        (display),
      .rs232_tx       (serial_loop)
   );

   always #2 clk = ~clk;

   task automatic report_mismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
      $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
   endtask

   task automatic report_failure(input string what);
      $display("Error at %0d ns: %s", $time, what);
      errors++;
   endtask

   // upper bits select the top 8 KB of the 22-bit space
   task automatic bus_read(input logic [12:0] off, output logic [15:0] data,
                           output logic nd);
      @(negedge clk);
      address   = {9'h1ff, off};
      iopage_rd = 1'b1;
      #1;
      data = data_out;
      nd   = no_decode;
      @(negedge clk);
      iopage_rd = 1'b0;
   endtask

   task automatic bus_write(input logic [12:0] off, input logic [15:0] data,
                            input logic byte_op);
      @(negedge clk);
      address        = {9'h1ff, off};
      data_in        = data;
      iopage_byte_op = byte_op;
      iopage_wr      = 1'b1;
      @(negedge clk);
      iopage_wr      = 1'b0;
      iopage_byte_op = 1'b0;
   endtask

   task automatic pulse_ack(input int level);
      @(negedge clk);
      ack_ipl[level] = 1'b1;
      @(negedge clk);
      ack_ipl = 8'h00;
   endtask

   task automatic test_decode();
      logic [12:0] mapped [7];
      logic [15:0] rd;
      logic        nd;
      mapped = '{13'o17546, 13'o17560, 13'o17562, 13'o17564,
                 13'o17566, 13'o17570, 13'o17776};
      tests_run++;
      foreach (mapped[i])
      begin
         bus_read(mapped[i], rd, nd);
         if (nd !== 1'b0)
            report_mismatch("no_decode", {15'd0, nd}, 16'h0000);
      end
      bus_read(13'o17000, rd, nd);
      if (nd !== 1'b1)
         report_mismatch("no_decode", {15'd0, nd}, 16'h0001);
      if (rd !== 16'h002f)
         report_mismatch("data_out", rd, 16'h002f);
      // idle cycle on an unmapped offset
      @(negedge clk);
      address = {9'h1ff, 13'o17000};
      #1;
      if (no_decode !== 1'b0)
         report_mismatch("no_decode", {15'd0, no_decode}, 16'h0000);
   endtask

   task automatic test_console();
      logic [15:0] sw;
      logic [15:0] w1;
      logic [15:0] w2;
      logic [15:0] pv;
      logic [15:0] pw;
      logic [15:0] rd;
      logic        nd;
      tests_run++;
      sw = $urandom;
      @(negedge clk);
      switches = sw;
      bus_read(13'o17570, rd, nd);
      if (rd !== sw)
         report_mismatch("data_out", rd, sw);
      w1 = $urandom;
      bus_write(13'o17570, w1, 1'b0);
      if (display !== w1)
         report_mismatch("display", display, w1);
      // odd offset byte write lands in the high byte only
      w2 = $urandom;
      bus_write(13'o17571, w2, 1'b1);
      if (display !== {w2[15:8], w1[7:0]})
         report_mismatch("display", display, {w2[15:8], w1[7:0]});
      pv = $urandom;
      pw = $urandom;
      @(negedge clk);
      psw = pv;
      bus_write(13'o17776, pw, 1'b1);
      if (psw_io_wr !== 1'b1)
         report_mismatch("psw_io_wr", {15'd0, psw_io_wr}, 16'h0001);
      if (psw_out !== {pv[15:8], pw[7:0]})
         report_mismatch("psw_out", psw_out, {pv[15:8], pw[7:0]});
      @(negedge clk);
      if (psw_io_wr !== 1'b0)
         report_mismatch("psw_io_wr", {15'd0, psw_io_wr}, 16'h0000);
   endtask

   task automatic test_line_clock();
      logic [15:0] rd;
      logic        nd;
      int          count;
      tests_run++;
      // enable and clear the monitor so only a tick can request
      bus_write(13'o17546, 16'o000100, 1'b0);
      count = 0;
      while (interrupt !== 1'b1 && count < 2 * LINE_CLK_DIV)
      begin
         @(negedge clk);
         count++;
      end
      if (interrupt !== 1'b1)
      begin
         report_failure("line clock interrupt never arrived");
         bus_write(13'o17546, 16'h0000, 1'b0);
         return;
      end
      if (interrupt_ipl[6] !== 1'b1)
         report_mismatch("interrupt_ipl", {8'h00, interrupt_ipl}, 16'h0040);
      if (vector !== 8'o100)
         report_mismatch("vector", {8'h00, vector}, 16'o100);
      bus_read(13'o17546, rd, nd);
      if (rd[7] !== 1'b1)
         report_mismatch("lks[7]", {15'd0, rd[7]}, 16'h0001);
      pulse_ack(6);
      if (interrupt !== 1'b0)
         report_mismatch("interrupt", {15'd0, interrupt}, 16'h0000);
      bus_write(13'o17546, 16'o000100, 1'b0);
      bus_read(13'o17546, rd, nd);
      if (rd[7] !== 1'b0)
         report_mismatch("lks[7]", {15'd0, rd[7]}, 16'h0000);
      bus_write(13'o17546, 16'h0000, 1'b0);
   endtask

   task automatic test_loopback();
      logic [7:0]  b;
      logic [15:0] rd;
      logic        nd;
      int          count;
      tests_run++;
      b = $urandom;
      bus_write(13'o17566, {8'h00, b}, 1'b0);
      bus_read(13'o17564, rd, nd);
      if (rd[7] !== 1'b0)
         report_mismatch("xcsr[7]", {15'd0, rd[7]}, 16'h0000);
      count = 0;
      rd    = 16'h0000;
      while (rd[7] !== 1'b1 && count < 12 * BIT_PERIOD)
      begin
         bus_read(13'o17560, rd, nd);
         count++;
      end
      if (rd[7] !== 1'b1)
      begin
         report_failure("receive done never set after loopback send");
         return;
      end
      bus_read(13'o17562, rd, nd);
      if (rd[7:0] !== b)
         report_mismatch("rbuf", {8'h00, rd[7:0]}, {8'h00, b});
      bus_read(13'o17560, rd, nd);
      if (rd[7] !== 1'b0)
         report_mismatch("rcsr[7]", {15'd0, rd[7]}, 16'h0000);
      // stop bit still going out when receive finishes
      count = 0;
      rd    = 16'h0000;
      while (rd[7] !== 1'b1 && count < 2 * BIT_PERIOD)
      begin
         bus_read(13'o17564, rd, nd);
         count++;
      end
      if (rd[7] !== 1'b1)
         report_failure("transmit ready never returned after the frame");
   endtask

   task automatic test_priority();
      logic [7:0]  b;
      logic [15:0] rd;
      logic        nd;
      int          count;
      tests_run++;
      bus_write(13'o17560, 16'o000100, 1'b0);
      bus_write(13'o17546, 16'o000100, 1'b0);
      b = $urandom;
      bus_write(13'o17566, {8'h00, b}, 1'b0);
      count = 0;
      while ((interrupt_ipl & 8'h50) !== 8'h50 && count < 4 * LINE_CLK_DIV)
      begin
         @(negedge clk);
         count++;
      end
      if ((interrupt_ipl & 8'h50) !== 8'h50)
      begin
         report_failure("clock and terminal requests never pending together");
         return;
      end
      if (vector !== 8'o100)
         report_mismatch("vector", {8'h00, vector}, 16'o100);
      // stop further ticks from re-raising the clock request
      bus_write(13'o17546, 16'h0000, 1'b0);
      pulse_ack(6);
      if (vector !== 8'o60)
         report_mismatch("vector", {8'h00, vector}, 16'o60);
      if (interrupt_ipl[6] !== 1'b0)
         report_mismatch("interrupt_ipl", {8'h00, interrupt_ipl}, 16'h0010);
      pulse_ack(4);
      if (interrupt !== 1'b0)
         report_mismatch("interrupt", {15'd0, interrupt}, 16'h0000);
      bus_read(13'o17562, rd, nd);
      if (rd[7:0] !== b)
         report_mismatch("rbuf", {8'h00, rd[7:0]}, {8'h00, b});
      bus_write(13'o17560, 16'h0000, 1'b0);
   endtask

   initial
   begin
      errors         = 0;
      tests_run      = 0;
      clk            = 1'b0;
      rst            = 1'b1;
      address        = 22'd0;
      data_in        = 16'h0000;
      iopage_rd      = 1'b0;
      iopage_wr      = 1'b0;
      iopage_byte_op = 1'b0;
      ack_ipl        = 8'h00;
      psw            = 16'h0000;
      switches       = 16'h0000;
      void'($urandom(2777));
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      test_decode();
      test_console();
      test_line_clock();
      test_loopback();
      test_priority();

      $display("tests run: %0d, errors: %0d", tests_run, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- compile.f
hw/iopage_pkg.sv
hw/tt_serial.sv
hw/tt_regs.sv
hw/clk_regs.sv
hw/console_regs.sv
hw/iopage.sv
tests/tb_iopage.sv
